// ==== hw/board_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_store #(
    parameter int max_rows  = 11,
    parameter int max_cols  = 11,
    parameter int line_w    = 11,
    parameter int max_lines = 22
) (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            load,
    input  wire  [$clog2(max_rows+1)-1:0]  num_rows,
    input  wire  [$clog2(max_cols+1)-1:0]  num_cols,
    input  wire                            hdr_take,
    input  wire                            line_write,
    input  wire  [line_w-1:0]              fifo_data,
    input  wire  [line_w-1:0]              always_one,
    input  wire  [line_w-1:0]              always_zero,
    output logic [line_w-1:0]              line_known,
    output logic [line_w-1:0]              line_assigned,
    output logic [max_rows*max_cols-1:0]   known,
    output logic [max_rows*max_cols-1:0]   assigned,
    output logic                           board_solved
);
    localparam int idx_w = $clog2(max_lines);
    localparam int cells = max_rows * max_cols;

    logic [$clog2(max_rows+1)-1:0] rows_q;
    logic [$clog2(max_cols+1)-1:0] cols_q;
    logic [idx_w-1:0]              line_idx;
    logic [idx_w-1:0]              col_idx;
    logic                          is_row;
    logic [line_w-1:0]             fix;
    logic [cells-1:0]              cell_we;
    logic [cells-1:0]              cell_val;

    assign is_row  = (line_idx < rows_q);
    assign col_idx = line_idx - idx_w'(rows_q);  // columns follow the rows
    // both set only when no option survived, leave those cells alone
    assign fix     = always_one ^ always_zero;

    // board is row major, cell (r,c) at r*max_cols+c
    always_comb begin
        int k;
        line_known    = '0;
        line_assigned = '0;
        cell_we       = '0;
        cell_val      = '0;
        board_solved  = 1'b1;
        for (int r = 0; r < max_rows; r++) begin
            for (int c = 0; c < max_cols; c++) begin
                k = r * max_cols + c;
                if (is_row && r == line_idx) begin
                    line_known[c]    = known[k];
                    line_assigned[c] = assigned[k];
                    cell_we[k]       = fix[c] && (c < cols_q);
                    cell_val[k]      = always_one[c];
                end
                if (!is_row && c == col_idx) begin  // transposed, bit r is row r
                    line_known[r]    = known[k];
                    line_assigned[r] = assigned[k];
                    cell_we[k]       = fix[r] && (r < rows_q);
                    cell_val[k]      = always_one[r];
                end
                if (r < rows_q && c < cols_q && !known[k]) begin
                    board_solved = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rows_q   <= '0;
            cols_q   <= '0;
            known    <= '0;
            assigned <= '0;
        end else if (load) begin
            rows_q   <= num_rows;  // board size held for the whole solve
            cols_q   <= num_cols;
            known    <= '0;
            assigned <= '0;
        end else if (line_write) begin
            known    <= known | cell_we;
            assigned <= (assigned & ~cell_we) | (cell_val & cell_we);
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_take) begin
            line_idx <= fifo_data[idx_w-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== hw/line_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_fsm import nono_pkg::*; (
    input  wire  clk,
    input  wire  rst,
    input  wire  start,
    input  wire  fifo_empty,
    input  wire  last_option,
    input  wire  board_solved,
    output logic fifo_rd,
    output logic hdr_take,
    output logic opt_take,
    output logic line_write,
    output logic load,
    output logic solved,
    output logic busy
);
    solver_state_t state;
    solver_state_t state_next;

    // pop only with data at the head, never once the board is done
    assign fifo_rd = !fifo_empty &&
                     ((state == FETCH_LINE && !board_solved) || state == SCAN_OPTIONS);

    assign hdr_take   = fifo_rd && (state == FETCH_LINE);
    assign opt_take   = fifo_rd && (state == SCAN_OPTIONS);
    assign line_write = (state == WRITE_LINE);
    assign load       = start && (state == IDLE || state == SOLVED); // start ignored mid-solve
    assign solved     = (state == SOLVED);
    assign busy       = (state == FETCH_LINE) || (state == SCAN_OPTIONS) ||
                        (state == WRITE_LINE);

    always_comb begin
        state_next = state;
        case (state)
            IDLE, SOLVED: begin
                if (start) begin
                    state_next = FETCH_LINE;
                end
            end
            FETCH_LINE: begin
                if (board_solved) begin
                    state_next = SOLVED;
                end else if (hdr_take) begin
                    state_next = SCAN_OPTIONS;
                end
            end
            SCAN_OPTIONS: begin
                if (opt_take && last_option) begin
                    state_next = WRITE_LINE;  // final option of the line
                end
            end
            WRITE_LINE: begin
                state_next = FETCH_LINE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

// ==== hw/line_merger.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_merger #(
    parameter int line_w = 11
) (
    input  wire               clk,
    input  wire               rst,
    input  wire               hdr_take,
    input  wire               opt_take,
    input  wire  [line_w-1:0] fifo_data,
    input  wire  [line_w-1:0] line_known,
    input  wire  [line_w-1:0] line_assigned,
    output logic              opt_ok,
    output logic [line_w-1:0] always_one,
    output logic [line_w-1:0] always_zero
);
    // rejected when any known cell differs from the candidate
    assign opt_ok = ~|((fifo_data ^ line_assigned) & line_known);

    // bits stay set only while every surviving option agrees
    always_ff @(posedge clk) begin
        if (rst) begin
            always_one  <= '1;
            always_zero <= '1;
        end else if (hdr_take) begin
            always_one  <= '1;  // new line, nothing seen yet
            always_zero <= '1;
        end else if (opt_take && opt_ok) begin
            always_one  <= always_one & fifo_data;
            always_zero <= always_zero & ~fifo_data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/nono_pkg.sv ====
`default_nettype none

package nono_pkg;

    // width of one option count, up to 127 options per line
    localparam int CNT_W = 7;

    // one lane walks the queue line by line
    typedef enum logic [2:0] {
        IDLE,
        FETCH_LINE,     // wait for and pop the next line header
        SCAN_OPTIONS,   // one option per pop
        WRITE_LINE,     // fix agreed cells, store survivor count
        SOLVED
    } solver_state_t;

endpackage

`default_nettype wire

// ==== hw/nono_solver_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module nono_solver_top import nono_pkg::*; #(
    parameter int max_rows = 11,
    parameter int max_cols = 11
) (
    input  wire                                          clk,
    input  wire                                          rst,
    input  wire                                          start,
    input  wire  [$clog2(max_rows+1)-1:0]                num_rows,
    input  wire  [$clog2(max_cols+1)-1:0]                num_cols,
    input  wire  [max_rows+max_cols-1:0][CNT_W-1:0]      counts_in,
    input  wire  [((max_rows > max_cols) ? max_rows : max_cols)-1:0] fifo_data,
    input  wire                                          fifo_empty,
    output logic                                         fifo_rd,
    output logic                                         put_valid,
    output logic [((max_rows > max_cols) ? max_rows : max_cols)-1:0] put_data,
    output logic [max_rows*max_cols-1:0]                 known,
    output logic [max_rows*max_cols-1:0]                 assigned,
    output logic                                         solved,
    output logic                                         busy
);
    localparam int line_w    = (max_rows > max_cols) ? max_rows : max_cols;
    localparam int max_lines = max_rows + max_cols;

    logic              hdr_take;
    logic              opt_take;
    logic              line_write;
    logic              load;
    logic              last_option;
    logic              board_solved;
    logic              opt_ok;
    logic [line_w-1:0] always_one;
    logic [line_w-1:0] always_zero;
    logic [line_w-1:0] line_known;
    logic [line_w-1:0] line_assigned;

    line_fsm u_fsm (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .fifo_empty   (fifo_empty),
        .last_option  (last_option),
        .board_solved (board_solved),
        .fifo_rd      (fifo_rd),
        .hdr_take     (hdr_take),
        .opt_take     (opt_take),
        .line_write   (line_write),
        .load         (load),
        .solved       (solved),
        .busy         (busy)
    );

    option_counter #(.line_w(line_w), .max_lines(max_lines)) u_counter (
        .clk         (clk),
        .rst         (rst),
        .load        (load),
        .counts_in   (counts_in),
        .hdr_take    (hdr_take),
        .opt_take    (opt_take),
        .opt_ok      (opt_ok),
        .line_write  (line_write),
        .fifo_data   (fifo_data),
        .last_option (last_option)
    );

    line_merger #(.line_w(line_w)) u_merger (
        .clk           (clk),
        .rst           (rst),
        .hdr_take      (hdr_take),
        .opt_take      (opt_take),
        .fifo_data     (fifo_data),
        .line_known    (line_known),
        .line_assigned (line_assigned),
        .opt_ok        (opt_ok),
        .always_one    (always_one),
        .always_zero   (always_zero)
    );

    board_store #(
        .max_rows  (max_rows),
        .max_cols  (max_cols),
        .line_w    (line_w),
        .max_lines (max_lines)
    ) u_board (
        .clk           (clk),
        .rst           (rst),
        .load          (load),
        .num_rows      (num_rows),
        .num_cols      (num_cols),
        .hdr_take      (hdr_take),
        .line_write    (line_write),
        .fifo_data     (fifo_data),
        .always_one    (always_one),
        .always_zero   (always_zero),
        .line_known    (line_known),
        .line_assigned (line_assigned),
        .known         (known),
        .assigned      (assigned),
        .board_solved  (board_solved)
    );

    // header always goes back, options only when they survive
    always_ff @(posedge clk) begin
        if (rst) begin
            put_valid <= 1'b0;
        end else begin
            put_valid <= hdr_take || (opt_take && opt_ok);
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_take || opt_take) begin
            put_data <= fifo_data;  // word popped this cycle
        end
    end

endmodule

`default_nettype wire

// ==== hw/option_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module option_counter import nono_pkg::*; #(
    parameter int line_w    = 11,
    parameter int max_lines = 22
) (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                load,
    input  wire  [max_lines-1:0][CNT_W-1:0]    counts_in,
    input  wire                                hdr_take,
    input  wire                                opt_take,
    input  wire                                opt_ok,
    input  wire                                line_write,
    input  wire  [line_w-1:0]                  fifo_data,
    output logic                               last_option
);
    localparam int idx_w = $clog2(max_lines);

    logic [max_lines-1:0][CNT_W-1:0] count_tbl;  // options per line index
    logic [idx_w-1:0]                line_idx;
    logic [CNT_W-1:0]                opts_left;  // still to pop for this line
    logic [CNT_W-1:0]                survivors;

    always_ff @(posedge clk) begin
        if (load) begin
            count_tbl <= counts_in;
        end else if (line_write) begin
            count_tbl[line_idx] <= survivors;  // shrinks as options are ruled out
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_take) begin
            line_idx <= fifo_data[idx_w-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            opts_left <= '0;
            survivors <= '0;
        end else if (hdr_take) begin
            opts_left <= count_tbl[fifo_data[idx_w-1:0]];
            survivors <= '0;
        end else if (opt_take) begin
            opts_left <= opts_left - 1'b1;
            if (opt_ok) begin
                survivors <= survivors + 1'b1;
            end
        end
    end

    assign last_option = (opts_left == CNT_W'(1));

endmodule

`default_nettype wire

// ==== list.f ====
hw/nono_pkg.sv
hw/line_fsm.sv
hw/option_counter.sv
hw/line_merger.sv
hw/board_store.sv
hw/nono_solver_top.sv
verification/nono_assertions.sv
verification/tb_nono_solver.sv

// ==== run.sh ====
#!/bin/sh
# build and run the nonogram solver testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f list.f --top-module tb_nono_solver -o sim_nono

out=$(./obj_dir/sim_nono)
echo "$out"

if echo "$out" | grep -q "RESULT: PASS"; then
    exit 0
fi
exit 1

// ==== verification/nono_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module nono_assertions #(
    parameter int cells = 121
) (
    input wire             clk,
    input wire             rst,
    input wire             start,
    input wire             fifo_rd,
    input wire             fifo_empty,
    input wire             put_valid,
    input wire             solved,
    input wire [cells-1:0] known
);
    no_pop_when_empty: assert property (@(posedge clk) disable iff (rst)
        fifo_empty |-> !fifo_rd)
        else $error("fifo_rd high while the queue is empty");

    no_pop_when_solved: assert property (@(posedge clk) disable iff (rst)
        solved |-> !fifo_rd)
        else $error("fifo_rd high after the board is solved");

    put_after_pop: assert property (@(posedge clk) disable iff (rst)
        put_valid |-> $past(fifo_rd))
        else $error("put_valid without a pop in the cycle before");

    // known cells only go away on a new start
    known_sticky: assert property (@(posedge clk) disable iff (rst)
        !start |=> ((known & $past(known)) == $past(known)))
        else $error("a known cell was cleared during a solve");

endmodule

bind nono_solver_top nono_assertions #(.cells(max_rows * max_cols)) u_assertions (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .fifo_rd    (fifo_rd),
    .fifo_empty (fifo_empty),
    .put_valid  (put_valid),
    .solved     (solved),
    .known      (known)
);

`default_nettype wire

// ==== verification/tb_nono_solver.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_nono_solver import nono_pkg::*; ();
    localparam logic [15:0] solution    = 16'h369f;  // rows 3..0, cell (r,c) at r*4+c
    localparam int          watchdog_ns = 10 * 2000; // ten times the expected run

    logic                   clk;
    logic                   rst;
    logic                   start;
    logic [2:0]             num_rows;
    logic [2:0]             num_cols;
    logic [7:0][CNT_W-1:0]  counts_in;
    logic [3:0]             fifo_data;
    logic                   fifo_empty;
    logic                   fifo_rd;
    logic                   put_valid;
    logic [3:0]             put_data;
    logic [15:0]            known;
    logic [15:0]            assigned;
    logic                   solved;
    logic                   busy;

    logic [3:0]  q[$];         // queue contents, head first
    logic [3:0]  puts[$];      // every word put back
    logic [3:0]  exp_puts[$];
    logic [3:0]  opt_list [8][3];
    int          cnt [8];
    logic [15:0] sh_known;     // board as the line rules predict it
    logic [15:0] sh_assigned;
    logic        stall;
    logic        rd_s;
    logic        pv_s;
    logic [3:0]  pd_s;
    int          errors = 0;
    int          tests = 0;

    nono_solver_top #(.max_rows(4), .max_cols(4)) dut (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .num_rows   (num_rows),
        .num_cols   (num_cols),
        .counts_in  (counts_in),
        .fifo_data  (fifo_data),
        .fifo_empty (fifo_empty),
        .fifo_rd    (fifo_rd),
        .put_valid  (put_valid),
        .put_data   (put_data),
        .known      (known),
        .assigned   (assigned),
        .solved     (solved),
        .busy       (busy)
    );

    always #5 clk = ~clk;

    // show-ahead queue, strobes sampled mid-cycle and applied after the edge
    always begin
        @(negedge clk);
        rd_s = fifo_rd;
        pv_s = put_valid;
        pd_s = put_data;
        @(posedge clk);
        #1;
        if (rd_s) begin
            void'(q.pop_front());
        end
        if (pv_s) begin
            q.push_back(pd_s);
            puts.push_back(pd_s);
        end
        fifo_empty = stall || (q.size() == 0);
        fifo_data  = (q.size() > 0) ? q[0] : 4'h0;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: the solver did not finish within %0d ns", watchdog_ns);
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("error %s: expected %h, got %h", name, exp, got);
        errors++;
    endtask

    // lines 0..3 are rows, 4..7 are columns
    function automatic int cell_of(input int idx, input int i);
        return (idx < 4) ? idx * 4 + i : i * 4 + (idx - 4);
    endfunction

    task automatic set_line(input int idx, input int n, input logic [3:0] a,
                            input logic [3:0] b, input logic [3:0] c);
        opt_list[idx][0] = a;
        opt_list[idx][1] = b;
        opt_list[idx][2] = c;
        cnt[idx]         = n;
    endtask

    task automatic load_options();
        set_line(0, 1, 4'b1111, 4'b0000, 4'b0000);  // clue 4
        set_line(1, 3, 4'b0101, 4'b1001, 4'b1010);  // clue 1 1
        set_line(2, 3, 4'b0011, 4'b0110, 4'b1100);  // clue 2
        set_line(3, 3, 4'b0011, 4'b0110, 4'b1100);
        set_line(4, 1, 4'b1011, 4'b0000, 4'b0000);  // clue 2 1
        set_line(5, 1, 4'b1101, 4'b0000, 4'b0000);  // clue 1 2
        set_line(6, 3, 4'b0101, 4'b1001, 4'b1010);  // col 2 drops 1010 once row 0 is set
        set_line(7, 3, 4'b0011, 4'b0110, 4'b1100);
    endtask

    task automatic fill_queue();
        q.delete();
        puts.delete();
        exp_puts.delete();
        for (int l = 0; l < 8; l++) begin
            q.push_back(4'(l));
            for (int k = 0; k < cnt[l]; k++) begin
                q.push_back(opt_list[l][k]);
            end
        end
    endtask

    // expected put words and board update for one line
    task automatic model_line(input int idx);
        logic [3:0] one;
        logic [3:0] zero;
        logic       fits;
        int         n;
        int         c;
        one  = 4'hf;
        zero = 4'hf;
        n    = 0;
        exp_puts.push_back(4'(idx));
        for (int k = 0; k < cnt[idx]; k++) begin
            fits = 1'b1;
            for (int i = 0; i < 4; i++) begin
                c = cell_of(idx, i);
                if (sh_known[c] && sh_assigned[c] != opt_list[idx][k][i]) begin
                    fits = 1'b0;
                end
            end
            if (fits) begin
                exp_puts.push_back(opt_list[idx][k]);
                one  = one & opt_list[idx][k];
                zero = zero & ~opt_list[idx][k];
                opt_list[idx][n] = opt_list[idx][k];
                n++;
            end
        end
        cnt[idx] = n;
        for (int i = 0; i < 4; i++) begin
            if (n > 0 && (one[i] || zero[i])) begin
                sh_known[cell_of(idx, i)]    = 1'b1;
                sh_assigned[cell_of(idx, i)] = one[i];
            end
        end
    endtask

    task automatic check_reset();
        tests++;
        @(negedge clk);
        if ({solved, busy, fifo_rd, put_valid} !== 4'b0000) begin
            report_mismatch("reset strobes", 0, {solved, busy, fifo_rd, put_valid});
        end
        if (known !== 16'h0) report_mismatch("reset known", 0, known);
    endtask

    task automatic run_solve(input string name);
        string tag;
        int    line;
        int    seen;
        int    limit;
        tests++;
        @(negedge clk);
        load_options();
        fill_queue();
        sh_known    = '0;
        sh_assigned = '0;
        @(posedge clk);
        #1;
        for (int l = 0; l < 8; l++) begin
            counts_in[l] = CNT_W'(cnt[l]);
        end
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        @(negedge clk);
        if (known !== 16'h0) report_mismatch({name, " start known"}, 0, known);
        if (busy !== 1'b1) report_mismatch({name, " start busy"}, 1, busy);
        line = 0;
        seen = 0;
        while (sh_known != 16'hffff) begin
            model_line(line);
            tag   = $sformatf("%s line %0d", name, line);
            limit = 0;
            // next header put back means this line is written
            while (puts.size() <= exp_puts.size() && !solved && limit < 200) begin
                @(negedge clk);
                limit++;
            end
            if (limit == 200) begin
                $display("%s: no put words came back for this line", tag);
                errors++;
                break;
            end
            for (int j = seen; j < exp_puts.size(); j++) begin
                if (j >= puts.size() || puts[j] !== exp_puts[j]) begin
                    report_mismatch({tag, " put"}, exp_puts[j],
                                    (j < puts.size()) ? puts[j] : 4'hx);
                end
            end
            seen = exp_puts.size();
            if (known !== sh_known) report_mismatch({tag, " known"}, sh_known, known);
            if (assigned !== sh_assigned) begin
                report_mismatch({tag, " assigned"}, sh_assigned, assigned);
            end
            line = (line + 1) % 8;
        end
        limit = 0;
        while (!solved && limit < 50) begin
            @(negedge clk);
            limit++;
        end
        if (!solved) begin
            $display("%s: solved never rose after the last line", name);
            errors++;
        end
        if (assigned !== solution) report_mismatch({name, " solution"}, solution, assigned);
        if (known !== 16'hffff) report_mismatch({name, " known"}, 16'hffff, known);
        repeat (3) begin
            @(negedge clk);
            if (fifo_rd || fifo_empty) begin
                $display("%s: queue not left alone after solved", name);
                errors++;
            end
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        start      = 1'b0;
        stall      = 1'b0;
        fifo_empty = 1'b1;
        fifo_data  = 4'h0;
        num_rows   = 3'd4;
        num_cols   = 3'd4;
        counts_in  = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        check_reset();
        run_solve("first solve");
        fork
            run_solve("restart");
            begin
                repeat (20) @(negedge clk);
                stall = 1'b1;  // queue looks empty for a while
                repeat (6) @(negedge clk);
                stall = 1'b0;
            end
        join
        $display("tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
